// File: Makefile
# Verilator flow for the image gradient subsystem

TB_BIN = obj_dir/tb_ig_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module ig_top -f ig_top.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_ig_top -f ig_top.f -o tb_ig_top
	./$(TB_BIN) | tee /dev/stderr | grep -q '^STATUS: PASS$$'

clean:
	rm -rf obj_dir

// File: ig_config.svh
`ifndef IG_CONFIG_SVH
`define IG_CONFIG_SVH

// --------------------------------------------------
// image geometry
// --------------------------------------------------

// pixels per row
`define IG_IMG_W 16

// rows per image
`define IG_IMG_H 16

// --------------------------------------------------
// data widths
// --------------------------------------------------

// unsigned grayscale pixel
`define IG_PIX_W 8

// one signed gradient field, a word holds gx and gy
`define IG_GRAD_W 10

`endif

// File: ig_grad_writer.sv
`timescale 1ns/1ns
`include "ig_config.svh"

module ig_grad_writer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    output logic                     done,
    input  logic                     grad_req,
    output logic                     grad_ack,
    input  ig_pkg::grad_beat_t       grad_data,
    output logic                     grad_wr,
    output ig_pkg::addr_t            grad_addr,
    output logic [2*`IG_GRAD_W-1:0]  grad_do,
    input  logic                     grad_wait
);

    // grad_wr and grad_ack double as the state, idle when both low
    logic take;
    logic write_done;
    logic last_r;

    assign take       = grad_req && !grad_wr && !grad_ack;
    assign write_done = grad_wr && !grad_wait;

    // --------------------------------------------------
    // write and handshake
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr  <= 1'b0;
            grad_ack <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (take) begin
                grad_wr <= 1'b1;
            end else if (write_done) begin
                // ack only once the memory has taken the word
                grad_wr  <= 1'b0;
                grad_ack <= 1'b1;
                if (last_r) begin
                    done <= 1'b1;
                end
            end else if (grad_ack && !grad_req) begin
                grad_ack <= 1'b0;
            end

            // end of the run handshake
            if (done && !start) begin
                done <= 1'b0;
            end
        end
    end

    // word held steady while grad_wait is high
    always_ff @(posedge clk) begin
        if (take) begin
            grad_addr <= grad_data.addr;
            grad_do   <= {grad_data.gx, grad_data.gy};
            last_r    <= grad_data.last;
        end
    end

endmodule

// File: ig_gradient_core.sv
`timescale 1ns/1ns
`include "ig_config.svh"

module ig_gradient_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                pix_req,
    output logic                pix_ack,
    input  ig_pkg::pixel_beat_t pix_data,
    output logic                grad_req,
    input  logic                grad_ack,
    output ig_pkg::grad_beat_t  grad_data
);

    localparam int unsigned NUM_PIX = `IG_IMG_W * `IG_IMG_H;
    localparam int FILL_W = $clog2(`IG_IMG_W + 1);
    localparam int COL_W  = $clog2(`IG_IMG_W);
    localparam int ROW_W  = $clog2(`IG_IMG_H);

    typedef enum logic [1:0] {
        ST_ACCEPT,
        ST_EMIT,
        ST_WAIT_ACK,
        ST_ACK_LOW
    } state_t;

    state_t state;

    // win[0] is the pixel being output, win[1] its right neighbour,
    // win[W] the pixel below it
    logic [`IG_PIX_W-1:0] win [0:`IG_IMG_W];

    logic [FILL_W-1:0] fill;
    logic              in_last;
    logic [COL_W-1:0]  col;
    logic [ROW_W-1:0]  row;
    ig_pkg::addr_t     out_addr;

    logic accept_fire;
    logic flush_fire;
    logic last_col;
    logic last_row;
    logic last_pix;

    function automatic logic signed [`IG_GRAD_W-1:0] pix_diff(
        input logic [`IG_PIX_W-1:0] a,
        input logic [`IG_PIX_W-1:0] b
    );
        logic signed [`IG_GRAD_W-1:0] sa;
        logic signed [`IG_GRAD_W-1:0] sb;
        // zero extend first, both pixels are unsigned
        sa = $signed(`IG_GRAD_W'(a));
        sb = $signed(`IG_GRAD_W'(b));
        return sa - sb;
    endfunction

    assign last_col = (col == COL_W'(`IG_IMG_W - 1));
    assign last_row = (row == ROW_W'(`IG_IMG_H - 1));
    assign last_pix = (out_addr == ig_pkg::addr_t'(NUM_PIX - 1));

    assign accept_fire = (state == ST_ACCEPT) && pix_req && !pix_ack;
    // after the last input the last row drains without new pixels
    assign flush_fire  = (state == ST_ACK_LOW) && !grad_ack && in_last && !last_pix;

    // --------------------------------------------------
    // control
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_ACCEPT;
            pix_ack  <= 1'b0;
            grad_req <= 1'b0;
            fill     <= '0;
            in_last  <= 1'b0;
            col      <= '0;
            row      <= '0;
            out_addr <= '0;
        end else begin
            if (pix_ack && !pix_req) begin
                pix_ack <= 1'b0;
            end

            case (state)
                ST_ACCEPT: begin
                    if (accept_fire) begin
                        pix_ack <= 1'b1;
                        in_last <= pix_data.last;
                        // window full means pixel below is now in place
                        if (fill == FILL_W'(`IG_IMG_W)) begin
                            state <= ST_EMIT;
                        end else begin
                            fill <= fill + 1'b1;
                        end
                    end
                end
                ST_EMIT: begin
                    grad_req <= 1'b1;
                    state    <= ST_WAIT_ACK;
                end
                ST_WAIT_ACK: begin
                    if (grad_ack) begin
                        grad_req <= 1'b0;
                        state    <= ST_ACK_LOW;
                    end
                end
                ST_ACK_LOW: begin
                    if (!grad_ack) begin
                        if (last_pix) begin
                            // image finished, ready for the next run
                            out_addr <= '0;
                            col      <= '0;
                            row      <= '0;
                            fill     <= '0;
                            in_last  <= 1'b0;
                            state    <= ST_ACCEPT;
                        end else begin
                            out_addr <= out_addr + 1'b1;
                            if (last_col) begin
                                col <= '0;
                                row <= row + 1'b1;
                            end else begin
                                col <= col + 1'b1;
                            end
                            state <= in_last ? ST_EMIT : ST_ACCEPT;
                        end
                    end
                end
                default: begin
                    state <= ST_ACCEPT;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // window and gradient beat
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept_fire || flush_fire) begin
            for (int k = 0; k < `IG_IMG_W; k++) begin
                win[k] <= win[k+1];
            end
            if (accept_fire) begin
                win[`IG_IMG_W] <= pix_data.pix;
            end
        end

        if (state == ST_EMIT) begin
            grad_data.gx   <= last_col ? '0 : pix_diff(win[1], win[0]);
            grad_data.gy   <= last_row ? '0 : pix_diff(win[`IG_IMG_W], win[0]);
            grad_data.addr <= out_addr;
            grad_data.last <= last_pix;
        end
    end

endmodule

// File: ig_hs_buffer.sv
`timescale 1ns/1ns
`include "ig_config.svh"

module ig_hs_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_req,
    output logic     in_ack,
    input  payload_t in_data,
    output logic     out_req,
    input  logic     out_ack,
    output payload_t out_data
);

    // entry holds a beat that has not finished its output cycle
    logic     full;
    logic     capture;
    payload_t data_q;

    // new beat only when the entry is free and the last input cycle is over
    assign capture  = in_req && !in_ack && !full;
    assign out_data = data_q;

    // --------------------------------------------------
    // handshake state
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack  <= 1'b0;
            full    <= 1'b0;
            out_req <= 1'b0;
        end else begin
            // input side
            if (capture) begin
                in_ack <= 1'b1;
                full   <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            // output side, req waits for the previous ack to fall
            if (full && !out_req && !out_ack) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req <= 1'b0;
                full    <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // payload
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= in_data;
        end
    end

endmodule

// File: ig_image_reader.sv
`timescale 1ns/1ns
`include "ig_config.svh"

module ig_image_reader (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    output logic                 img_rd,
    output ig_pkg::addr_t        img_addr,
    input  logic [`IG_PIX_W-1:0] img_di,
    output logic                 pix_req,
    input  logic                 pix_ack,
    output ig_pkg::pixel_beat_t  pix_data
);

    localparam int unsigned NUM_PIX = `IG_IMG_W * `IG_IMG_H;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_CAPTURE,
        ST_REQ,
        ST_ACK_LOW
    } state_t;

    state_t        state;
    ig_pkg::addr_t addr;
    // set for the whole sweep, cleared only once start is low again
    logic          busy;

    assign img_rd   = (state == ST_READ);
    assign img_addr = addr;

    // --------------------------------------------------
    // sweep control
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            addr    <= '0;
            busy    <= 1'b0;
            pix_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start && !busy) begin
                        busy  <= 1'b1;
                        addr  <= '0;
                        state <= ST_READ;
                    end else if (!start) begin
                        busy <= 1'b0;
                    end
                end
                // memory answers one cycle later
                ST_READ: begin
                    state <= ST_CAPTURE;
                end
                ST_CAPTURE: begin
                    pix_req <= 1'b1;
                    state   <= ST_REQ;
                end
                ST_REQ: begin
                    if (pix_ack) begin
                        pix_req <= 1'b0;
                        state   <= ST_ACK_LOW;
                    end
                end
                // next read only after the four-phase cycle closes
                ST_ACK_LOW: begin
                    if (!pix_ack) begin
                        if (pix_data.last) begin
                            state <= ST_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= ST_READ;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // beat register, img_di is valid in the capture cycle
    always_ff @(posedge clk) begin
        if (state == ST_CAPTURE) begin
            pix_data.pix  <= img_di;
            pix_data.last <= (addr == ig_pkg::addr_t'(NUM_PIX - 1));
        end
    end

endmodule

// File: ig_pkg.sv
`include "ig_config.svh"

package ig_pkg;

    // --------------------------------------------------
    // addressing
    // --------------------------------------------------

    // wide enough for every pixel of the image
    localparam int ADDR_W = $clog2(`IG_IMG_W * `IG_IMG_H);

    typedef logic [ADDR_W-1:0] addr_t;

    // --------------------------------------------------
    // beats on the internal links
    // --------------------------------------------------

    // reader to core
    typedef struct packed {
        logic [`IG_PIX_W-1:0] pix;
        logic                 last;
    } pixel_beat_t;

    // core to writer, address travels with the data
    typedef struct packed {
        logic signed [`IG_GRAD_W-1:0] gx;
        logic signed [`IG_GRAD_W-1:0] gy;
        addr_t                        addr;
        logic                         last;
    } grad_beat_t;

endpackage

// File: ig_top.f
+incdir+.
ig_pkg.sv
ig_hs_buffer.sv
ig_image_reader.sv
ig_gradient_core.sv
ig_grad_writer.sv
ig_top.sv
tb_ig_mem.sv
tb_ig_top.sv

// File: ig_top.sv
`timescale 1ns/1ns
`include "ig_config.svh"

module ig_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    output logic                    done,
    output logic                    img_rd,
    output ig_pkg::addr_t           img_addr,
    input  logic [`IG_PIX_W-1:0]    img_di,
    output logic                    grad_wr,
    output ig_pkg::addr_t           grad_addr,
    output logic [2*`IG_GRAD_W-1:0] grad_do,
    input  logic                    grad_wait
);

    // --------------------------------------------------
    // links
    // --------------------------------------------------

    // reader to pixel buffer
    logic                rd_pix_req;
    logic                rd_pix_ack;
    ig_pkg::pixel_beat_t rd_pix_data;

    // pixel buffer to core
    logic                buf_pix_req;
    logic                buf_pix_ack;
    ig_pkg::pixel_beat_t buf_pix_data;

    // core to gradient buffer
    logic                core_grad_req;
    logic                core_grad_ack;
    ig_pkg::grad_beat_t  core_grad_data;

    // gradient buffer to writer
    logic                buf_grad_req;
    logic                buf_grad_ack;
    ig_pkg::grad_beat_t  buf_grad_data;

    ig_image_reader u_reader (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .pix_req  (rd_pix_req),
        .pix_ack  (rd_pix_ack),
        .pix_data (rd_pix_data)
    );

    ig_hs_buffer #(.payload_t(ig_pkg::pixel_beat_t)) u_pix_buf (
        .clk      (clk),
        .reset    (reset),
        .in_req   (rd_pix_req),
        .in_ack   (rd_pix_ack),
        .in_data  (rd_pix_data),
        .out_req  (buf_pix_req),
        .out_ack  (buf_pix_ack),
        .out_data (buf_pix_data)
    );

    ig_gradient_core u_core (
        .clk       (clk),
        .reset     (reset),
        .pix_req   (buf_pix_req),
        .pix_ack   (buf_pix_ack),
        .pix_data  (buf_pix_data),
        .grad_req  (core_grad_req),
        .grad_ack  (core_grad_ack),
        .grad_data (core_grad_data)
    );

    ig_hs_buffer #(.payload_t(ig_pkg::grad_beat_t)) u_grad_buf (
        .clk      (clk),
        .reset    (reset),
        .in_req   (core_grad_req),
        .in_ack   (core_grad_ack),
        .in_data  (core_grad_data),
        .out_req  (buf_grad_req),
        .out_ack  (buf_grad_ack),
        .out_data (buf_grad_data)
    );

    ig_grad_writer u_writer (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .done      (done),
        .grad_req  (buf_grad_req),
        .grad_ack  (buf_grad_ack),
        .grad_data (buf_grad_data),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .grad_wait (grad_wait)
    );

endmodule

// File: tb_ig_mem.sv
`timescale 1ns/1ns
`include "ig_config.svh"

// image memory with read data one cycle after img_rd
module image_model (
    input  logic                 clk,
    input  logic                 img_rd,
    input  ig_pkg::addr_t        img_addr,
    output logic [`IG_PIX_W-1:0] img_di
);

    localparam int NUM_PIX = `IG_IMG_W * `IG_IMG_H;

    // loaded by the testbench before each run
    logic [`IG_PIX_W-1:0] mem [0:NUM_PIX-1];
    logic [`IG_PIX_W-1:0] data_q = '0;
    // reads since time zero
    int unsigned          rd_count = 0;

    assign img_di = data_q;

    always @(posedge clk) begin
        if (img_rd) begin
            data_q   <= mem[img_addr];
            rd_count <= rd_count + 32'd1;
        end
    end

endmodule

// gradient memory that records every completed write
module grad_capture (
    input  logic                    clk,
    input  logic                    clear,
    input  int unsigned             stall_pct,
    input  logic                    grad_wr,
    input  ig_pkg::addr_t           grad_addr,
    input  logic [2*`IG_GRAD_W-1:0] grad_do,
    output logic                    grad_wait
);

    localparam int NUM_PIX = `IG_IMG_W * `IG_IMG_H;
    localparam int WORD_W  = 2 * `IG_GRAD_W;

    logic [WORD_W-1:0] mem [0:NUM_PIX-1];
    int unsigned       wr_count [0:NUM_PIX-1];
    int unsigned       total_writes;
    logic              wait_q = 1'b0;
    integer            seed = 32'h8605;
    integer            roll;

    assign grad_wait = wait_q;

    // --------------------------------------------------
    // write capture
    // --------------------------------------------------

    always @(posedge clk) begin
        if (clear) begin
            total_writes <= 0;
            for (int a = 0; a < NUM_PIX; a++) begin
                // stale pattern differs per address
                mem[ig_pkg::addr_t'(a)]      <= WORD_W'(32'h5a3c7 ^ (a * 32'd2654435761));
                wr_count[ig_pkg::addr_t'(a)] <= 0;
            end
        end else if (grad_wr && !grad_wait) begin
            mem[grad_addr]      <= grad_do;
            wr_count[grad_addr] <= wr_count[grad_addr] + 32'd1;
            total_writes        <= total_writes + 32'd1;
        end
    end

    // stall roll changes shortly after each edge
    always @(posedge clk) begin
        #1;
        roll   = $random(seed);
        wait_q <= ($unsigned(roll) % 32'd100) < stall_pct;
    end

endmodule

// File: tb_ig_top.sv
`timescale 1ns/1ns
`include "ig_config.svh"

module tb_ig_top;

    localparam int NUM_PIX     = `IG_IMG_W * `IG_IMG_H;
    localparam int WORD_W      = 2 * `IG_GRAD_W;
    localparam int NUM_TESTS   = 6;
    localparam int RUN_TIMEOUT = NUM_PIX * 64 + 1000;

    // image patterns
    localparam int PAT_FLAT   = 0;
    localparam int PAT_HRAMP  = 1;
    localparam int PAT_VRAMP  = 2;
    localparam int PAT_FALL   = 3;
    localparam int PAT_RANDOM = 4;

    logic                 clk;
    logic                 reset;
    logic                 start;
    logic                 done;
    logic                 img_rd;
    ig_pkg::addr_t        img_addr;
    logic [`IG_PIX_W-1:0] img_di;
    logic                 grad_wr;
    ig_pkg::addr_t        grad_addr;
    logic [WORD_W-1:0]    grad_do;
    logic                 grad_wait;
    logic                 clear;
    int unsigned          stall_pct;

    integer seed;
    int     errors;

    // --------------------------------------------------
    // test table of name, image pattern and stall percent
    // --------------------------------------------------

    string       test_name [NUM_TESTS] = '{"flat", "h_ramp", "v_ramp", "falling",
                                           "random_stall", "random_again"};
    int          test_pat [NUM_TESTS]  = '{PAT_FLAT, PAT_HRAMP, PAT_VRAMP, PAT_FALL,
                                           PAT_RANDOM, PAT_RANDOM};
    int unsigned test_stall [NUM_TESTS] = '{0, 0, 25, 40, 75, 10};

    ig_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .done      (done),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .grad_wait (grad_wait)
    );

    image_model u_img (
        .clk      (clk),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di)
    );

    grad_capture u_cap (
        .clk       (clk),
        .clear     (clear),
        .stall_pct (stall_pct),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .grad_wait (grad_wait)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [`IG_PIX_W-1:0] pattern_pixel(input int pat, input int x,
                                                            input int y);
        logic [`IG_PIX_W-1:0] v;
        case (pat)
            PAT_HRAMP:  v = `IG_PIX_W'(9 * x + 3);
            PAT_VRAMP:  v = `IG_PIX_W'(11 * y + 1);
            // falls in both directions for negative differences
            PAT_FALL:   v = `IG_PIX_W'(255 - 6 * x - 9 * y);
            PAT_RANDOM: v = `IG_PIX_W'($random(seed));
            default:    v = `IG_PIX_W'(77);
        endcase
        return v;
    endfunction

    // forward differences with 0 in the last column and last row
    function automatic logic [WORD_W-1:0] expected_word(input int a);
        int x;
        int y;
        int here;
        int gx;
        int gy;
        x    = a % `IG_IMG_W;
        y    = a / `IG_IMG_W;
        here = int'(u_img.mem[ig_pkg::addr_t'(a)]);
        gx   = 0;
        gy   = 0;
        if (x != `IG_IMG_W - 1) begin
            gx = int'(u_img.mem[ig_pkg::addr_t'(a + 1)]) - here;
        end
        if (y != `IG_IMG_H - 1) begin
            gy = int'(u_img.mem[ig_pkg::addr_t'(a + `IG_IMG_W)]) - here;
        end
        return {`IG_GRAD_W'(gx), `IG_GRAD_W'(gy)};
    endfunction

    task automatic check_equal(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("ERR %s %s expected %0h actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic fill_image(input int pat);
        for (int a = 0; a < NUM_PIX; a++) begin
            u_img.mem[ig_pkg::addr_t'(a)] = pattern_pixel(pat, a % `IG_IMG_W, a / `IG_IMG_W);
        end
    endtask

    // --------------------------------------------------
    // one run loads the image, runs start/done and compares
    // --------------------------------------------------

    task automatic run_test(input int idx, output bit ok);
        int          cycles;
        int unsigned reads_before;
        ok = 1'b1;
        fill_image(test_pat[idx]);
        stall_pct = test_stall[idx];
        clear     = 1'b1;
        @(posedge clk);
        #1;
        clear        = 1'b0;
        reads_before = u_img.rd_count;
        start        = 1'b1;
        cycles       = 0;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("timeout in test %s, done never rose after start", test_name[idx]);
            errors++;
            ok = 1'b0;
        end else begin
            // done must not come before the last write
            check_equal(test_name[idx], "writes at done", 32'(NUM_PIX), u_cap.total_writes);
            // one image read per pixel
            check_equal(test_name[idx], "reads at done", 32'(NUM_PIX),
                        u_img.rd_count - reads_before);
            // done holds while start is still high
            @(posedge clk);
            #1;
            check_equal(test_name[idx], "done while start high", 32'd1, 32'(done));
            start = 1'b0;
            @(posedge clk);
            #1;
            check_equal(test_name[idx], "done after start low", 32'd0, 32'(done));
            for (int a = 0; a < NUM_PIX; a++) begin
                check_equal(test_name[idx], $sformatf("addr %0d count", a), 32'd1,
                            u_cap.wr_count[ig_pkg::addr_t'(a)]);
                check_equal(test_name[idx], $sformatf("addr %0d word", a),
                            32'(expected_word(a)), 32'(u_cap.mem[ig_pkg::addr_t'(a)]));
            end
        end
    endtask

    initial begin
        bit ok;
        seed      = 32'h8605;
        errors    = 0;
        reset     = 1'b1;
        start     = 1'b0;
        clear     = 1'b0;
        stall_pct = 0;
        ok        = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;

        // idle outputs before the first start
        check_equal("reset", "img_rd", 32'd0, 32'(img_rd));
        check_equal("reset", "grad_wr", 32'd0, 32'(grad_wr));
        check_equal("reset", "done", 32'd0, 32'(done));

        // runs follow each other without a gap
        for (int t = 0; t < NUM_TESTS && ok; t++) begin
            run_test(t, ok);
        end

        $display("error count %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
